// ==== hw/mvuPkg.sv ====
package mvuPkg;

	// Operand widths
	localparam int unsigned WEIGHT_WIDTH = 8;	// Signed weights, lane layout depends on it
	localparam int unsigned ACTIVATION_WIDTH = 8;	// Unsigned unless the top level says otherwise
	localparam int unsigned PROD_WIDTH = WEIGHT_WIDTH + ACTIVATION_WIDTH;	// 16

	// Packed multiplier word holding two rows
	localparam int unsigned LANE_WORD_WIDTH = 58;
	localparam int unsigned LOWER_LANE_WIDTH = PROD_WIDTH;	// Low part of the lower row
	localparam int unsigned CANARY_WIDTH = 2;	// Borrow tracking bits
	localparam int unsigned UPPER_LANE_OFFSET = LOWER_LANE_WIDTH;	// Upper row weight shift
	localparam int unsigned UPPER_LANE_SPAN = LANE_WORD_WIDTH - UPPER_LANE_OFFSET;	// 42
	localparam int unsigned UPPER_FIELD_WIDTH = UPPER_LANE_SPAN - CANARY_WIDTH;	// Above canaries

	// Same 58 bits, read as one signed word or as lanes
	typedef union packed {
		logic signed [LANE_WORD_WIDTH-1:0] full;	// Multiply and accumulate view
		struct packed {
			logic [UPPER_FIELD_WIDTH-1:0] upper;	// Upper row above the canaries
			logic [CANARY_WIDTH-1:0] canary;	// Lowest upper-row bits
			logic [LOWER_LANE_WIDTH-1:0] lower;	// Lower row modulo 2**16
		} split;	// Canary compare and reduction view
	} laneWord_u;

endpackage

// ==== hw/mvuWeightMem.sv ====
module mvuWeightMem #(
	int unsigned PE = 4,	// Rows
	int unsigned SIMD = 4,	// Weights per row and fold
	int unsigned SF = 3,	// Folds
	localparam int unsigned ADDR_WIDTH = SF > 1 ? $clog2(SF) : 1
)(
	input logic clk,
	input logic rst,
	input logic wrEn,	// Host write strobe
	input logic [ADDR_WIDTH-1:0] wrAddr,	// Fold index of the write
	input logic signed [PE-1:0][SIMD-1:0][mvuPkg::WEIGHT_WIDTH-1:0] wrData,
	input logic rdEn,	// Low while stalled
	input logic [ADDR_WIDTH-1:0] rdAddr,	// Fold index from sequencer
	output logic signed [PE-1:0][SIMD-1:0][mvuPkg::WEIGHT_WIDTH-1:0] w
);
	import mvuPkg::*;

	// One full fold word per entry
	logic signed [PE-1:0][SIMD-1:0][WEIGHT_WIDTH-1:0] mem [SF];

	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrAddr] <= wrData;	// Whole fold at once
		end
	end

	// Registered read, held through a stall
	always_ff @(posedge clk) begin
		if (rst) begin
			w <= '0;
		end else if (rdEn) begin
			w <= mem[rdAddr];	// Lines up with the chunk register in sequencer
		end
	end

endmodule

// ==== hw/mvuSequencer.sv ====
module mvuSequencer #(
	int unsigned SIMD = 4,	// Elements per chunk
	int unsigned SF = 3,	// Chunks per vector
	localparam int unsigned ADDR_WIDTH = SF > 1 ? $clog2(SF) : 1
)(
	input logic clk,
	input logic rst,
	input logic aVld,	// Chunk strobe from host
	input logic [SIMD-1:0][mvuPkg::ACTIVATION_WIDTH-1:0] a,
	input logic stall,	// Freezes everything
	output logic rdEn,	// Weight read enable
	output logic [ADDR_WIDTH-1:0] rdAddr,	// Current fold
	output logic en,	// Core clock enable
	output logic last,	// Final fold of a vector
	output logic zero,	// No chunk this cycle
	output logic [SIMD-1:0][mvuPkg::ACTIVATION_WIDTH-1:0] aCore
);

	localparam logic [ADDR_WIDTH-1:0] LAST_FOLD = ADDR_WIDTH'(SF - 1);

	logic [ADDR_WIDTH-1:0] fold;	// Chunk counter
	logic accept;	// Chunk taken this cycle
	logic lastFold;	// Counter sits on the final fold

	assign accept = aVld && !stall;	// Chunks are dropped while stalled
	assign lastFold = fold == LAST_FOLD;

	// Fold counter, wraps after the final fold
	always_ff @(posedge clk) begin
		if (rst) begin
			fold <= '0;
		end else if (accept) begin
			fold <= lastFold ? '0 : fold + 1'b1;
		end
	end

	assign rdAddr = fold;	// Weight word for the chunk being offered
	assign rdEn = !stall;
	assign en = !stall;	// Whole core moves with the memory

	// Flags delayed one enabled cycle to meet the registered weight word
	always_ff @(posedge clk) begin
		if (rst) begin
			last <= 1'b0;
			zero <= 1'b1;	// Empty slots add nothing
		end else if (!stall) begin
			last <= accept && lastFold;
			zero <= !accept;	// Bubble enters as a zero product
		end
	end

	// Chunk travels with its flags
	always_ff @(posedge clk) begin
		if (!stall) begin
			aCore <= a;
		end
	end

endmodule

// ==== hw/mvuPackedDot.sv ====
module mvuPackedDot #(
	int unsigned PE = 4,	// Rows, packed two per lane word
	int unsigned SIMD = 4,	// Lanes per pair
	int unsigned ACCU_WIDTH = 20,	// Result width, up to the upper lane span
	bit SIGNED_ACTIVATIONS = 0
)(
	input logic clk,
	input logic rst,
	input logic en,	// Pipeline enable
	input logic last,	// Final fold of the vector
	input logic zero,	// Force this fold's product to zero
	input logic signed [PE-1:0][SIMD-1:0][mvuPkg::WEIGHT_WIDTH-1:0] w,
	input logic [SIMD-1:0][mvuPkg::ACTIVATION_WIDTH-1:0] a,
	output logic vld,
	output logic signed [PE-1:0][ACCU_WIDTH-1:0] p
);
	import mvuPkg::*;

	localparam int unsigned PAIRS = (PE + 1) / 2;

	// Last flag follows the data through all five stages
	logic [1:5] lastPipe;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0;
		end else if (en) begin
			lastPipe <= {last, lastPipe[1:4]};
		end
	end

	assign vld = lastPipe[5];	// Holds while en is low

	for (genvar c = 0; c < PAIRS; c++) begin : genPair

		// Leaves per kind: 0 lower lane, 1 upper lane, 2 borrow
		logic [ACCU_WIDTH-1:0] leaf [3][SIMD];
		logic [ACCU_WIDTH-1:0] node [3][2*SIMD-1];	// Heap ordered, root at 0
		logic [ACCU_WIDTH-1:0] lo4;	// Lower lane bits summed over SIMD
		logic [ACCU_WIDTH-1:0] up4;	// Upper lane summed, borrows still in
		logic [ACCU_WIDTH-1:0] hi4;	// Borrow total of the lower row
		logic [1:0][ACCU_WIDTH-1:0] res;	// 0 lower row, 1 upper row

		for (genvar s = 0; s < SIMD; s++) begin : genSimd
			logic signed [WEIGHT_WIDTH-1:0] wLo;
			logic signed [WEIGHT_WIDTH-1:0] wHi;
			logic signed [ACTIVATION_WIDTH:0] aExt;	// One extra bit for the sign
			logic [CANARY_WIDTH-1:0] canPred;	// Upper product mod 4
			logic signed [ACTIVATION_WIDTH:0] actS1;
			logic [CANARY_WIDTH-1:0] canS1;
			logic [CANARY_WIDTH-1:0] canS2;
			logic [CANARY_WIDTH-1:0] canS3;	// Expected canary without borrow
			logic signed [CANARY_WIDTH-1:0] borrow;	// Borrow from the lower row, -2..1
			logic [UPPER_LANE_SPAN-1:0] upperSpan;
			laneWord_u wordS1;	// Pre-added weight pair
			laneWord_u prodS2;	// Packed product
			laneWord_u accS3;	// Packed accumulator

			assign wLo = w[2*c][s];
			if (2*c + 1 < PE) begin : genHiRow
				assign wHi = w[2*c+1][s];
			end else begin : genNoHiRow
				assign wHi = '0;	// Odd PE leaves the upper slot empty
			end

			assign aExt = {SIGNED_ACTIVATIONS && a[s][ACTIVATION_WIDTH-1], a[s]};
			assign canPred = wHi[CANARY_WIDTH-1:0] * a[s][CANARY_WIDTH-1:0];	// Low bits only

			// Stage 1, zero gates the activation side
			always_ff @(posedge clk) begin
				if (rst) begin
					actS1 <= '0;
					canS1 <= '0;
				end else if (en) begin
					actS1 <= zero ? '0 : aExt;
					canS1 <= zero ? '0 : canPred;
				end
			end

			always_ff @(posedge clk) begin
				if (en) begin
					wordS1.full <= LANE_WORD_WIDTH'(wLo) +
						(LANE_WORD_WIDTH'(wHi) <<< UPPER_LANE_OFFSET);	// wLo + wHi * 2**16
				end
			end

			// Stage 2, one wide multiply for both rows
			always_ff @(posedge clk) begin
				if (rst) begin
					prodS2.full <= '0;
					canS2 <= '0;
				end else if (en) begin
					prodS2.full <= wordS1.full * LANE_WORD_WIDTH'(actS1);
					canS2 <= canS1;
				end
			end

			// Stage 3, accumulate, restart after the delayed last
			always_ff @(posedge clk) begin
				if (rst) begin
					accS3.full <= '0;
					canS3 <= '0;
				end else if (en) begin
					accS3.full <= prodS2.full + (lastPipe[3] ? '0 : accS3.full);
					canS3 <= canS2 + (lastPipe[3] ? '0 : accS3.split.canary);	// Carry canary on
				end
			end

			// Difference between seen and expected canary is this fold's borrow
			assign borrow = accS3.split.canary - canS3;
			assign upperSpan = {accS3.split.upper, accS3.split.canary};

			assign leaf[0][s] = ACCU_WIDTH'(accS3.split.lower);	// Zero extended
			assign leaf[1][s] = upperSpan[ACCU_WIDTH-1:0];
			assign leaf[2][s] = ACCU_WIDTH'(borrow);	// Sign extended
		end : genSimd

		// Adder trees across SIMD, modulo 2**ACCU_WIDTH
		always_comb begin
			for (int k = 0; k < 3; k++) begin
				for (int s = 0; s < int'(SIMD); s++) begin
					node[k][int'(SIMD)-1+s] = leaf[k][s];
				end
				for (int n = int'(SIMD) - 2; n >= 0; n--) begin
					node[k][n] = node[k][2*n+1] + node[k][2*n+2];
				end
			end
		end

		// Stage 4, borrows accumulate per vector, lanes are already totals
		always_ff @(posedge clk) begin
			if (rst) begin
				hi4 <= '0;
			end else if (en) begin
				hi4 <= (lastPipe[4] ? '0 : hi4) + node[2][0];
			end
		end

		always_ff @(posedge clk) begin
			if (en) begin
				lo4 <= node[0][0];
				up4 <= node[1][0];
			end
		end

		// Stage 5, move the borrows from the upper total back to the lower one
		always_ff @(posedge clk) begin
			if (en) begin
				res[1] <= up4 - hi4;
				res[0] <= (hi4 << LOWER_LANE_WIDTH) + lo4;
			end
		end

		assign p[2*c] = res[0];
		if (2*c + 1 < PE) begin : genUpperOut
			assign p[2*c+1] = res[1];
		end
	end : genPair

endmodule

// ==== hw/mvuTop.sv ====
module mvuTop #(
	int unsigned PE = 4,	// Matrix rows
	int unsigned SIMD = 4,	// Elements per chunk
	int unsigned SF = 3,	// Chunks per vector
	int unsigned ACCU_WIDTH = 20,	// Result width
	bit SIGNED_ACTIVATIONS = 0,	// Unsigned activations by default
	localparam int unsigned ADDR_WIDTH = SF > 1 ? $clog2(SF) : 1
)(
	input logic clk,
	input logic rst,
	input logic wrEn,	// Weight write strobe
	input logic [ADDR_WIDTH-1:0] wrAddr,	// Fold index
	input logic signed [PE-1:0][SIMD-1:0][mvuPkg::WEIGHT_WIDTH-1:0] wrData,
	input logic aVld,	// Chunk strobe
	input logic [SIMD-1:0][mvuPkg::ACTIVATION_WIDTH-1:0] a,
	input logic stall,	// Freeze level
	output logic vld,	// Result level
	output logic signed [PE-1:0][ACCU_WIDTH-1:0] p
);
	import mvuPkg::*;

	logic rdEn;
	logic [ADDR_WIDTH-1:0] rdAddr;
	logic en;
	logic last;
	logic zero;
	logic [SIMD-1:0][ACTIVATION_WIDTH-1:0] aCore;	// Chunk aligned with w
	logic signed [PE-1:0][SIMD-1:0][WEIGHT_WIDTH-1:0] w;	// Registered fold word

	mvuWeightMem #(
		.PE(PE),
		.SIMD(SIMD),
		.SF(SF)
	) weightMem0 (
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.w(w)
	);

	mvuSequencer #(
		.SIMD(SIMD),
		.SF(SF)
	) sequencer0 (
		.clk(clk),
		.rst(rst),
		.aVld(aVld),
		.a(a),
		.stall(stall),
		.rdEn(rdEn),
		.rdAddr(rdAddr),
		.en(en),
		.last(last),
		.zero(zero),
		.aCore(aCore)
	);

	mvuPackedDot #(
		.PE(PE),
		.SIMD(SIMD),
		.ACCU_WIDTH(ACCU_WIDTH),
		.SIGNED_ACTIVATIONS(SIGNED_ACTIVATIONS)
	) packedDot0 (
		.clk(clk),
		.rst(rst),
		.en(en),
		.last(last),
		.zero(zero),
		.w(w),
		.a(aCore),
		.vld(vld),
		.p(p)
	);

endmodule

// ==== include/mvuTbChecks.svh ====
`ifndef MVU_TB_CHECKS_SVH
`define MVU_TB_CHECKS_SVH

// Needs mvuPkg imported and SIMD, SF, ACCU_WIDTH visible where included

// Largest magnitude of a single weight times activation
localparam longint MAX_TERM = (longint'(1) << (WEIGHT_WIDTH - 1)) *
	((longint'(1) << ACTIVATION_WIDTH) - 1);

int resultErrors = 0;	// Wrong PE values
int countErrors = 0;	// Vector count mismatch
int timeoutErrors = 0;	// vld never came
int fileErrors = 0;	// Golden file missing or malformed

// One PE result against the golden value
task automatic checkResult(input int vecIdx, input int row,
		input logic signed [ACCU_WIDTH-1:0] got, input longint expected);
	longint bound;
	logic signed [ACCU_WIDTH-1:0] expWord;
	bound = longint'(SIMD) * longint'(SF) * MAX_TERM;	// Largest possible dot product
	expWord = ACCU_WIDTH'(expected);
	if (expected > bound || expected < -bound) begin
		resultErrors++;
		$display("error at %0t: vector %0d row %0d expected %0d is outside the operand range",
			$time, vecIdx, row, expected);
	end else if (got !== expWord) begin
		resultErrors++;
		$display("error at %0t: vector %0d row %0d got %0d expected %0d",
			$time, vecIdx, row, got, expWord);
	end
endtask

// Number of vectors seen against number sent
task automatic checkCount(input int got, input int expected);
	if (got != expected) begin
		countErrors++;
		$display("error at %0t: received %0d vectors, expected %0d", $time, got, expected);
	end
endtask

// Wait for vld ran out of cycles
task automatic noteTimeout(input int vecIdx, input int cycles);
	timeoutErrors++;
	$display("%0t ERROR timed out after %0d cycles waiting for the result of vector %0d",
		$time, cycles, vecIdx);
endtask

task automatic reportSummary();
	$display("Result errors %0d, count errors %0d, timeouts %0d, file errors %0d",
		resultErrors, countErrors, timeoutErrors, fileErrors);
	if (resultErrors + countErrors + timeoutErrors + fileErrors == 0) begin
		$display("Regression passed");
	end else begin
		$display("Regression failed");
	end
endtask

`endif

// ==== test/mvuTb.sv ====
module mvuTb;
	import mvuPkg::*;

	localparam int unsigned PE = 4;	// Same values the top level is built with
	localparam int unsigned SIMD = 4;
	localparam int unsigned SF = 3;
	localparam int unsigned ACCU_WIDTH = 20;
	localparam bit SIGNED_ACTIVATIONS = 0;
	localparam int unsigned ADDR_WIDTH = SF > 1 ? $clog2(SF) : 1;
	localparam int unsigned WORD_BITS = PE * SIMD * WEIGHT_WIDTH;	// One fold word
	localparam int unsigned CHUNK_BITS = SIMD * ACTIVATION_WIDTH;	// One activation chunk
	localparam int RESULT_LATENCY = 6;	// Unstalled cycles from final chunk to result
	localparam int DRAIN_LIMIT = 60;	// Cycles allowed for pending results

	`include "mvuTbChecks.svh"

	logic clk = 1'b0;
	logic rst;
	logic wrEn;
	logic [ADDR_WIDTH-1:0] wrAddr;
	logic signed [PE-1:0][SIMD-1:0][WEIGHT_WIDTH-1:0] wrData;
	logic aVld;
	logic [SIMD-1:0][ACTIVATION_WIDTH-1:0] a;
	logic stall;
	logic vld;
	logic signed [PE-1:0][ACCU_WIDTH-1:0] p;

	longint expQ[$];	// PE values per expected vector, row 0 first
	int lastQ[$];	// Active cycle index of each accepted final chunk
	int vecSent = 0;
	int vecSeen = 0;
	int activeIdx = 0;	// Counts unstalled cycles only
	int tbFold = 0;	// Own copy of the fold position
	bit randomStall = 0;
	int seed = 32'h6b4d;	// $random state

	always #4 clk = ~clk;	// Period 8

	mvuTop #(
		.PE(PE),
		.SIMD(SIMD),
		.SF(SF),
		.ACCU_WIDTH(ACCU_WIDTH),
		.SIGNED_ACTIVATIONS(SIGNED_ACTIVATIONS)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.aVld(aVld),
		.a(a),
		.stall(stall),
		.vld(vld),
		.p(p)
	);

	// Compare one delivered vector and its latency
	task automatic takeResult();
		int lastIdx;
		if (expQ.size() < int'(PE)) begin
			resultErrors++;
			$display("error at %0t: result delivered with no vector pending", $time);
		end else begin
			for (int r = 0; r < int'(PE); r++) begin
				checkResult(vecSeen, r, p[r], expQ.pop_front());
			end
			if (lastQ.size() > 0) begin
				lastIdx = lastQ.pop_front();
				if (activeIdx - lastIdx != RESULT_LATENCY) begin
					resultErrors++;
					$display("error at %0t: vector %0d took %0d cycles, expected %0d",
						$time, vecSeen, activeIdx - lastIdx, RESULT_LATENCY);
				end
			end
		end
		vecSeen++;	// Every delivery counts, expected or not
	endtask

	// Drive on the falling edge, then look at the outputs of this cycle
	task automatic driveCycle(input logic wrEnV, input logic [ADDR_WIDTH-1:0] wrAddrV,
			input logic [WORD_BITS-1:0] wrDataV, input logic aVldV,
			input logic [CHUNK_BITS-1:0] aV, input logic stallV);
		@(negedge clk);
		wrEn = wrEnV;
		wrAddr = wrAddrV;
		wrData = wrDataV;
		aVld = aVldV;
		a = aV;
		stall = stallV;
		if (vld && !stallV) begin
			takeResult();	// Delivered only on an unstalled cycle
		end
		if (aVldV && !stallV) begin
			if (tbFold == int'(SF) - 1) begin
				lastQ.push_back(activeIdx);
				tbFold = 0;
			end else begin
				tbFold++;
			end
		end
		if (!stallV) begin
			activeIdx++;
		end
	endtask

	// One chunk slot, with extra stalls in front of it when random mode is on
	task automatic offerCycle(input logic aVldV, input logic [CHUNK_BITS-1:0] aV,
			input logic stallV);
		int extra;
		extra = randomStall ? int'($unsigned($random(seed)) % 3) : 0;
		for (int i = 0; i < extra; i++) begin
			driveCycle(1'b0, '0, '0, aVldV, aV, 1'b1);	// Same chunk held back
		end
		driveCycle(1'b0, '0, '0, aVldV, aV, stallV);
	endtask

	// Idle until every expected vector came back or the limit runs out
	task automatic drainResults(output bit drained);
		int waited;
		waited = 0;
		while (expQ.size() > 0 && waited < DRAIN_LIMIT) begin
			offerCycle(1'b0, '0, 1'b0);
			waited++;
		end
		drained = expQ.size() == 0;
		if (!drained) begin
			noteTimeout(vecSeen, waited);
		end
	endtask

	task automatic resetDut();
		@(negedge clk);
		rst = 1'b1;
		wrEn = 1'b0;
		aVld = 1'b0;
		stall = 1'b0;
		repeat (3) @(negedge clk);	// Three rising edges in reset
		rst = 1'b0;
		tbFold = 0;	// Partial vector is gone
		lastQ.delete();
	endtask

	initial begin
		int fd;
		int n;
		int addrV;
		int vldV;
		int stallV;
		int modeV;
		int ev [4];
		bit drained;
		bit stopped;
		string line;
		string kind;
		logic [WORD_BITS-1:0] wordV;
		logic [CHUNK_BITS-1:0] chunkV;
		rst = 1'b0;
		wrEn = 1'b0;
		wrAddr = '0;
		wrData = '0;
		aVld = 1'b0;
		a = '0;
		stall = 1'b0;
		stopped = 1'b0;
		resetDut();
		fd = $fopen("test/mvuGolden.txt", "r");
		if (fd == 0) begin
			fileErrors++;
			$display("Cannot open the golden file test/mvuGolden.txt");
		end else begin
			while (!stopped && $fgets(line, fd) > 0) begin
				n = $sscanf(line, "%s", kind);
				if (n < 1 || kind.getc(0) == "#") begin
					continue;	// Blank or comment
				end
				if (kind == "w") begin
					n = $sscanf(line, "w %d %h", addrV, wordV);
					driveCycle(1'b1, ADDR_WIDTH'(addrV), wordV, 1'b0, '0, 1'b0);
				end else if (kind == "c") begin
					n = $sscanf(line, "c %d %d %h", vldV, stallV, chunkV);
					offerCycle(vldV != 0, chunkV, stallV != 0);
				end else if (kind == "e") begin
					n = $sscanf(line, "e %d %d %d %d", ev[0], ev[1], ev[2], ev[3]);
					for (int r = 0; r < int'(PE); r++) begin
						expQ.push_back(longint'(ev[r]));
					end
					vecSent++;
				end else if (kind == "x") begin
					n = $sscanf(line, "x %d", modeV);
					randomStall = modeV != 0;
				end else if (kind == "r") begin
					drainResults(drained);	// Earlier vectors finish first
					if (drained) begin
						resetDut();
					end else begin
						stopped = 1'b1;
					end
				end else begin
					fileErrors++;
					$display("Golden file line not understood: %s", line);
					stopped = 1'b1;
				end
			end
			$fclose(fd);
			if (!stopped) begin
				drainResults(drained);
				if (drained) begin
					checkCount(vecSeen, vecSent);
				end
			end
		end
		reportSummary();
		$finish;
	end

endmodule

// ==== test/mvuGolden.txt ====
# w <fold> <weights hex, row 3 lane 3 first> | c <aVld> <stall> <chunk hex, lane 3 first>
# e <rows 0..3 signed decimal> | x <random stalls 1 on, 0 off> | r reset
w 0 fffffffffb05f60a000000ff04030201
w 1 ffffffff00000000000000fe01010101
w 2 ffffffff04030201000000fd02000000
# one vector without gaps
c 1 0 04030201
c 1 0 281e140a
c 1 0 c8000064
e 530 -321 885 -410
# bubbles between chunks, data without aVld is ignored
c 1 0 04030201
c 0 0 00000000
c 0 0 ffffffff
c 1 0 281e140a
c 0 0 12345678
c 1 0 c8000064
e 530 -321 885 -410
# back to back vectors
c 1 0 ffffffff
c 1 0 00000000
c 1 0 01010101
e 2552 -258 10 -1024
c 1 0 00000005
c 1 0 00000007
c 1 0 09000000
e 30 -19 86 -21
# random stalls, one chunk dropped under stall and sent again
x 1
c 1 0 04030201
c 1 1 281e140a
c 1 0 281e140a
c 1 0 c8000064
e 530 -321 885 -410
c 1 0 ffffffff
c 0 1 00000000
c 1 0 00000000
c 1 0 01010101
e 2552 -258 10 -1024
x 0
# extreme weights, the two rows of each pair have opposite signs
w 0 7f7f7f7f80808080808080807f7f7f7f
w 1 7f7f7f7f80808080808080807f7f7f7f
w 2 7f7f7f7f80808080808080807f7f7f7f
c 1 0 ffffffff
c 1 0 ffffffff
c 1 0 ffffffff
e 388620 -391680 -391680 388620
c 1 0 ff00ff00
c 1 0 00ff00ff
c 1 0 ffffffff
e 259080 -261120 -261120 259080
# reset in the middle of a vector, weights stay loaded
c 1 0 ffffffff
c 1 0 ffffffff
r
c 1 0 ffffffff
c 1 0 ffffffff
c 1 0 ffffffff
e 388620 -391680 -391680 388620

// ==== flist.f ====
+incdir+include
hw/mvuPkg.sv
hw/mvuWeightMem.sv
hw/mvuSequencer.sv
hw/mvuPackedDot.sv
hw/mvuTop.sv
test/mvuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MVU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module mvuTb -o mvuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mvuSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides pass or fail
if grep -q "Regression failed" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0
